/* source/cam_pkg.sv */
`default_nettype none

package cam_pkg;

    // Camera side
    localparam int DVP_DATA_W = 8;
    typedef logic [DVP_DATA_W-1:0] pix_t;

    // Display side
    localparam int DBI_DATA_W = 8;
    typedef logic [DBI_DATA_W-1:0] dbi_data_t;

    // Pixel buffer between the two sides
    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
    typedef logic [FIFO_AW-1:0] fifo_ptr_t;

    // Display bring-up and command set
    localparam int DSP_RESET_CYCLES         = 16;      // RESX low time after reset
    localparam dbi_data_t DSP_CMD_MEM_WRITE = 8'h2C;   // Memory write

    typedef enum logic [1:0] {
        CTRL_RESET,
        CTRL_WAIT_FRAME,
        CTRL_SEND_CMD,
        CTRL_STREAM
    } ctrl_state_t;

endpackage

`default_nettype wire

/* source/dvp_sampler.sv */
`default_nettype none

module dvp_sampler (
    input  wire                 sys_clk,
    input  wire                 rst_i,
    input  wire cam_pkg::pix_t  dvp_d_i,
    input  wire                 dvp_href_i,
    input  wire                 dvp_vsync_i,
    input  wire                 dvp_pclk_i,
    output logic                pix_valid_o,
    output cam_pkg::pix_t       pix_data_o,
    output logic                frame_start_o
);

    // Bits 1:0 are the synchronizer, bit 2 keeps the previous value
    logic [2:0]     pclk_sync;
    logic [2:0]     vsync_sync;
    logic [1:0]     href_sync;
    cam_pkg::pix_t  d_meta;
    cam_pkg::pix_t  d_sync;
    logic           pclk_rise;
    logic           vsync_rise;

    always_ff @(posedge sys_clk) begin
        if (rst_i) begin
            pclk_sync  <= '0;
            vsync_sync <= '0;
            href_sync  <= '0;
        end else begin
            pclk_sync  <= {pclk_sync[1:0], dvp_pclk_i};
            vsync_sync <= {vsync_sync[1:0], dvp_vsync_i};
            href_sync  <= {href_sync[0], dvp_href_i};
        end
    end

    // Data bus follows the same two stages as pclk
    always_ff @(posedge sys_clk) begin
        d_meta <= dvp_d_i;
        d_sync <= d_meta;
    end

    assign pclk_rise  = pclk_sync[1] & ~pclk_sync[2];
    assign vsync_rise = vsync_sync[1] & ~vsync_sync[2];

    always_ff @(posedge sys_clk) begin
        if (rst_i) begin
            pix_valid_o   <= 1'b0;
            frame_start_o <= 1'b0;
        end else begin
            pix_valid_o   <= pclk_rise & href_sync[1];  // Only bytes inside a line
            frame_start_o <= vsync_rise;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (pclk_rise) begin
            pix_data_o <= d_sync;
        end
    end

endmodule

`default_nettype wire

/* source/pixel_fifo.sv */
`default_nettype none

module pixel_fifo (
    input  wire                 sys_clk,
    input  wire                 rst_i,
    input  wire                 push_i,
    input  wire cam_pkg::pix_t  wdata_i,
    input  wire                 pop_i,
    output cam_pkg::pix_t       rdata_o,
    output logic                empty_o,
    output logic                full_o
);

    cam_pkg::pix_t              mem [cam_pkg::FIFO_DEPTH];
    cam_pkg::fifo_ptr_t         wr_ptr;
    cam_pkg::fifo_ptr_t         rd_ptr;
    logic [cam_pkg::FIFO_AW:0]  count;
    logic                       do_push;
    logic                       do_pop;

    assign do_push = push_i && !full_o;    // Overflow is dropped
    assign do_pop  = pop_i && !empty_o;

    assign empty_o = (count == '0);
    assign full_o  = (count == (cam_pkg::FIFO_AW + 1)'(cam_pkg::FIFO_DEPTH));
    assign rdata_o = mem[rd_ptr];           // Show-ahead head entry

    always_ff @(posedge sys_clk) begin
        if (rst_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata_i;
        end
    end

endmodule

`default_nettype wire

/* source/dbi_writer.sv */
`default_nettype none

module dbi_writer (
    input  wire                     sys_clk,
    input  wire                     rst_i,
    input  wire                     wr_start_i,
    input  wire                     wr_dcx_i,
    input  wire cam_pkg::dbi_data_t wr_data_i,
    output logic                    wr_busy_o,
    output logic                    dbi_dcx_o,
    output logic                    dbi_wrx_o,
    output cam_pkg::dbi_data_t      dbi_d_o
);

    typedef enum logic {
        WR_IDLE,
        WR_STROBE
    } wr_phase_t;

    wr_phase_t  phase;
    logic       accept;

    // A request during the strobe phase is not taken
    assign accept = wr_start_i && (phase == WR_IDLE);

    always_ff @(posedge sys_clk) begin
        if (rst_i) begin
            phase     <= WR_IDLE;
            dbi_dcx_o <= 1'b1;
        end else begin
            case (phase)
                WR_IDLE: begin
                    if (accept) begin
                        phase     <= WR_STROBE;
                        dbi_dcx_o <= wr_dcx_i;
                    end
                end
                WR_STROBE: begin
                    phase <= WR_IDLE;   // WRX returns high, display latches here
                end
                default: begin
                    phase <= WR_IDLE;
                end
            endcase
        end
    end

    // Bus holds its value until the next write
    always_ff @(posedge sys_clk) begin
        if (accept) begin
            dbi_d_o <= wr_data_i;
        end
    end

    assign dbi_wrx_o = (phase != WR_STROBE);
    assign wr_busy_o = (phase == WR_STROBE);

endmodule

`default_nettype wire

/* source/stream_ctrl.sv */
`default_nettype none

module stream_ctrl (
    input  wire                 sys_clk,
    input  wire                 rst_i,
    input  wire                 frame_start_i,
    input  wire                 fifo_empty_i,
    input  wire cam_pkg::pix_t  fifo_rdata_i,
    input  wire                 wr_busy_i,
    output logic                fifo_pop_o,
    output logic                wr_start_o,
    output logic                wr_dcx_o,
    output cam_pkg::dbi_data_t  wr_data_o,
    output logic                dbi_resx_o,
    output logic                dbi_csx_o
);

    cam_pkg::ctrl_state_t                           state;
    logic [$clog2(cam_pkg::DSP_RESET_CYCLES)-1:0]   rst_cnt;
    logic                                           frame_pend;
    logic                                           wr_idle;
    logic                                           issue_cmd;
    logic                                           issue_pix;

    // Writer is free next cycle only if nothing was started this cycle
    assign wr_idle   = !wr_busy_i && !wr_start_o;
    assign issue_cmd = (state == cam_pkg::CTRL_SEND_CMD) && fifo_empty_i && wr_idle;
    assign issue_pix = (state == cam_pkg::CTRL_STREAM) && !fifo_empty_i && wr_idle;

    always_ff @(posedge sys_clk) begin
        if (rst_i) begin
            state      <= cam_pkg::CTRL_RESET;
            rst_cnt    <= '0;
            frame_pend <= 1'b0;
            fifo_pop_o <= 1'b0;
            wr_start_o <= 1'b0;
            wr_dcx_o   <= 1'b1;
            dbi_resx_o <= 1'b0;
            dbi_csx_o  <= 1'b1;
        end else begin
            fifo_pop_o <= 1'b0;
            wr_start_o <= 1'b0;
            case (state)
                cam_pkg::CTRL_RESET: begin
                    if (rst_cnt == $bits(rst_cnt)'(cam_pkg::DSP_RESET_CYCLES - 1)) begin
                        dbi_resx_o <= 1'b1;
                        dbi_csx_o  <= 1'b0;    // Select the display for good
                        state      <= cam_pkg::CTRL_WAIT_FRAME;
                    end else begin
                        rst_cnt <= rst_cnt + 1'b1;
                    end
                end
                cam_pkg::CTRL_WAIT_FRAME: begin
                    // Bytes outside a frame are thrown away
                    if (!fifo_empty_i && !fifo_pop_o) begin
                        fifo_pop_o <= 1'b1;
                    end
                    if (frame_start_i) begin
                        state <= cam_pkg::CTRL_SEND_CMD;
                    end
                end
                cam_pkg::CTRL_SEND_CMD: begin
                    if (issue_cmd) begin
                        wr_start_o <= 1'b1;
                        wr_dcx_o   <= 1'b0;
                        state      <= cam_pkg::CTRL_STREAM;
                    end
                end
                cam_pkg::CTRL_STREAM: begin
                    if (frame_start_i) begin
                        frame_pend <= 1'b1;
                    end
                    if (issue_pix) begin
                        fifo_pop_o <= 1'b1;
                        wr_start_o <= 1'b1;
                        wr_dcx_o   <= 1'b1;
                    end else if ((frame_pend || frame_start_i) && fifo_empty_i) begin
                        frame_pend <= 1'b0;    // Old frame fully drained
                        state      <= cam_pkg::CTRL_SEND_CMD;
                    end
                end
                default: begin
                    state <= cam_pkg::CTRL_RESET;
                end
            endcase
        end
    end

    // Write payload, only meaningful with wr_start_o
    always_ff @(posedge sys_clk) begin
        if (issue_cmd) begin
            wr_data_o <= cam_pkg::DSP_CMD_MEM_WRITE;
        end else if (issue_pix) begin
            wr_data_o <= fifo_rdata_i;
        end
    end

endmodule

`default_nettype wire

/* source/image_stream_top.sv */
`default_nettype none

module image_stream_top (
    input  wire                     sys_clk,
    input  wire                     rst_i,
    // Camera
    input  wire cam_pkg::pix_t      dvp_d_i,
    input  wire                     dvp_href_i,
    input  wire                     dvp_vsync_i,
    input  wire                     dvp_pclk_i,
    // Display
    output wire                     dbi_dcx_o,
    output wire                     dbi_csx_o,
    output wire                     dbi_resx_o,
    output wire                     dbi_wrx_o,
    output cam_pkg::dbi_data_t      dbi_d_o
);

    // Camera side
    logic                   pix_valid;
    cam_pkg::pix_t          pix_data;
    logic                   frame_start;
    // Buffer
    logic                   fifo_empty;
    cam_pkg::pix_t          fifo_rdata;
    logic                   fifo_pop;
    // Display side
    logic                   wr_start;
    logic                   wr_dcx;
    cam_pkg::dbi_data_t     wr_data;
    logic                   wr_busy;

    dvp_sampler u_dvp_sampler (
        .sys_clk        (sys_clk),
        .rst_i          (rst_i),
        .dvp_d_i        (dvp_d_i),
        .dvp_href_i     (dvp_href_i),
        .dvp_vsync_i    (dvp_vsync_i),
        .dvp_pclk_i     (dvp_pclk_i),
        .pix_valid_o    (pix_valid),
        .pix_data_o     (pix_data),
        .frame_start_o  (frame_start)
    );

    pixel_fifo u_pixel_fifo (
        .sys_clk        (sys_clk),
        .rst_i          (rst_i),
        .push_i         (pix_valid),
        .wdata_i        (pix_data),
        .pop_i          (fifo_pop),
        .rdata_o        (fifo_rdata),
        .empty_o        (fifo_empty),
        .full_o         ()              // No back-pressure toward the camera
    );

    stream_ctrl u_stream_ctrl (
        .sys_clk        (sys_clk),
        .rst_i          (rst_i),
        .frame_start_i  (frame_start),
        .fifo_empty_i   (fifo_empty),
        .fifo_rdata_i   (fifo_rdata),
        .wr_busy_i      (wr_busy),
        .fifo_pop_o     (fifo_pop),
        .wr_start_o     (wr_start),
        .wr_dcx_o       (wr_dcx),
        .wr_data_o      (wr_data),
        .dbi_resx_o     (dbi_resx_o),
        .dbi_csx_o      (dbi_csx_o)
    );

    dbi_writer u_dbi_writer (
        .sys_clk        (sys_clk),
        .rst_i          (rst_i),
        .wr_start_i     (wr_start),
        .wr_dcx_i       (wr_dcx),
        .wr_data_i      (wr_data),
        .wr_busy_o      (wr_busy),
        .dbi_dcx_o      (dbi_dcx_o),
        .dbi_wrx_o      (dbi_wrx_o),
        .dbi_d_o        (dbi_d_o)
    );

endmodule

`default_nettype wire

/* dv/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen (
    output logic clk_o,
    output logic rst_o
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 3;

    initial begin
        clk_o = 1'b0;
        forever #10 clk_o = ~clk_o;    // 20 ns period
    end

    initial begin
        rst_o = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_o <= 1'b0;
    end

endmodule

`default_nettype wire

/* dv/tb_image_stream.sv */
`default_nettype none

module tb_image_stream;

    timeunit 1ns;
    timeprecision 1ps;

    // Stimulus layout in pclk periods
    localparam int PCLK_CYCLES = 10;
    localparam int PRE_IDLE    = 2;
    localparam int PRE_BYTES   = 4;     // Clocked before the first vsync
    localparam int PRE_GAP     = 3;
    localparam int N_FRAMES    = 3;
    localparam int VS_LEN      = 2;
    localparam int VS_GAP      = 2;
    localparam int N_LINES     = 4;
    localparam int LINE_LEN    = 6;
    localparam int LINE_GAP    = 2;     // href low while data still toggles
    localparam int TAIL        = 3;
    localparam int N_PERIODS   = PRE_IDLE + PRE_BYTES + PRE_GAP + TAIL
                               + N_FRAMES * (VS_LEN + VS_GAP + N_LINES * (LINE_LEN + LINE_GAP));
    localparam int TIMEOUT_CYCLES = 2 * N_PERIODS * PCLK_CYCLES + 200;
    localparam int DRAIN_CYCLES   = 4 * PCLK_CYCLES;

    logic               sys_clk;
    logic               rst;
    cam_pkg::pix_t      dvp_d;
    logic               dvp_href;
    logic               dvp_vsync;
    logic               dvp_pclk;
    logic               dbi_dcx;
    logic               dbi_csx;
    logic               dbi_resx;
    logic               dbi_wrx;
    cam_pkg::dbi_data_t dbi_d;

    cam_pkg::pix_t      stim_d_q[$];
    logic               stim_href_q[$];
    logic               stim_vsync_q[$];
    cam_pkg::dbi_data_t exp_data_q[$];
    logic               exp_dcx_q[$];
    int                 exp_frame_q[$];
    cam_pkg::dbi_data_t got_data_q[$];
    logic               got_dcx_q[$];

    logic [31:0]        lcg_state;
    int                 compared = 0;
    int                 byte_errors = 0;
    int                 dcx_errors = 0;
    int                 cycle_errors = 0;
    int                 pin_errors = 0;
    int                 protocol_errors = 0;
    int                 cycle_cnt;

    tb_clock_gen u_clock_gen (
        .clk_o  (sys_clk),
        .rst_o  (rst)
    );

    image_stream_top dut (
        .sys_clk     (sys_clk),
        .rst_i       (rst),
        .dvp_d_i     (dvp_d),
        .dvp_href_i  (dvp_href),
        .dvp_vsync_i (dvp_vsync),
        .dvp_pclk_i  (dvp_pclk),
        .dbi_dcx_o   (dbi_dcx),
        .dbi_csx_o   (dbi_csx),
        .dbi_resx_o  (dbi_resx),
        .dbi_wrx_o   (dbi_wrx),
        .dbi_d_o     (dbi_d)
    );

    function automatic cam_pkg::pix_t next_random_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];
    endfunction

    function automatic void add_period(input logic vsync, input logic href);
        stim_vsync_q.push_back(vsync);
        stim_href_q.push_back(href);
        stim_d_q.push_back(next_random_byte());
    endfunction

    function automatic void build_stimulus();
        repeat (PRE_IDLE) add_period(1'b0, 1'b0);
        repeat (PRE_BYTES) add_period(1'b0, 1'b1);
        repeat (PRE_GAP) add_period(1'b0, 1'b0);
        repeat (N_FRAMES) begin
            repeat (VS_LEN) add_period(1'b1, 1'b0);
            repeat (VS_GAP) add_period(1'b0, 1'b0);
            repeat (N_LINES) begin
                repeat (LINE_LEN) add_period(1'b0, 1'b1);
                repeat (LINE_GAP) add_period(1'b0, 1'b0);
            end
        end
        repeat (TAIL) add_period(1'b0, 1'b0);
    endfunction

    // Expected writes are one command per vsync then the href-high bytes
    function automatic void build_expected();
        logic in_frame;
        logic prev_vsync;
        int   frame;
        int   i;
        in_frame   = 1'b0;
        prev_vsync = 1'b0;
        frame      = 0;
        for (i = 0; i < stim_d_q.size(); i++) begin
            if (stim_vsync_q[i] && !prev_vsync) begin
                in_frame = 1'b1;
                frame++;
                exp_dcx_q.push_back(1'b0);
                exp_data_q.push_back(8'h2C);
                exp_frame_q.push_back(frame);
            end else if (in_frame && stim_href_q[i]) begin
                exp_dcx_q.push_back(1'b1);
                exp_data_q.push_back(stim_d_q[i]);
                exp_frame_q.push_back(frame);
            end
            prev_vsync = stim_vsync_q[i];
        end
    endfunction

    task automatic check_dbi_byte(input string name, input cam_pkg::dbi_data_t exp,
                                  input cam_pkg::dbi_data_t act);
        if (act !== exp) begin
            byte_errors++;
            $display("Fail %s data: expected %02h, got %02h", name, exp, act);
        end
    endtask

    task automatic check_dcx(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            dcx_errors++;
            $display("Fail %s dcx: expected %0b, got %0b", name, exp, act);
        end
    endtask

    task automatic check_pin(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            pin_errors++;
            $display("Fail %s: expected %0b, got %0b", name, exp, act);
        end
    endtask

    task automatic check_cycles(input string name, input int exp, input int act);
        if (act != exp) begin
            cycle_errors++;
            $display("Fail %s: expected %0d cycles, got %0d", name, exp, act);
        end
    endtask

    task automatic print_counts();
        $display("Errors: byte %0d, dcx %0d, cycles %0d, pin %0d, protocol %0d",
                 byte_errors, dcx_errors, cycle_errors, pin_errors, protocol_errors);
    endtask

    // Display reset and chip select after rst
    int   rst_low_cycles;
    logic resx_released = 1'b0;

    always @(posedge sys_clk) begin
        if (rst) begin
            rst_low_cycles = 0;
            resx_released  = 1'b0;
        end else if (!resx_released) begin
            if (dbi_resx === 1'b1) begin
                check_cycles("display reset release", cam_pkg::DSP_RESET_CYCLES, rst_low_cycles);
                check_pin("dbi_csx_o at reset release", 1'b0, dbi_csx);
                resx_released = 1'b1;
            end else begin
                check_pin("dbi_resx_o during display reset", 1'b0, dbi_resx);
                check_pin("dbi_csx_o during display reset", 1'b1, dbi_csx);
                check_pin("dbi_wrx_o during display reset", 1'b1, dbi_wrx);
            end
            rst_low_cycles++;
        end
    end

    // A low WRX sampled at this edge means the display latches here
    logic               wrx_low_prev = 1'b0;
    logic               hold_pending = 1'b0;
    cam_pkg::dbi_data_t hold_d;
    logic               hold_dcx;
    int                 n_writes = 0;

    always @(posedge sys_clk) begin
        if (rst) begin
            wrx_low_prev = 1'b0;
            hold_pending = 1'b0;
        end else begin
            if (hold_pending) begin
                check_dbi_byte($sformatf("hold after write %0d", n_writes - 1), hold_d, dbi_d);
                check_dcx($sformatf("hold after write %0d", n_writes - 1), hold_dcx, dbi_dcx);
                hold_pending = 1'b0;
            end
            if (!dbi_wrx) begin
                if (wrx_low_prev) begin
                    protocol_errors++;
                    $display("dbi_wrx_o stayed low for more than one cycle after write %0d",
                             n_writes - 1);
                end else begin
                    got_data_q.push_back(dbi_d);
                    got_dcx_q.push_back(dbi_dcx);
                    // Bus must still carry the expected write after WRX rises
                    if (n_writes < exp_data_q.size()) begin
                        hold_d       = exp_data_q[n_writes];
                        hold_dcx     = exp_dcx_q[n_writes];
                        hold_pending = 1'b1;
                    end
                    n_writes++;
                end
            end
            wrx_low_prev = !dbi_wrx;
        end
    end

    always @(posedge sys_clk) begin : compare_writes
        cam_pkg::dbi_data_t d;
        logic               c;
        string              name;
        while (got_data_q.size() > 0) begin
            d = got_data_q.pop_front();
            c = got_dcx_q.pop_front();
            if (compared < exp_data_q.size()) begin
                name = $sformatf("frame %0d write %0d", exp_frame_q[compared], compared);
                check_dcx(name, exp_dcx_q[compared], c);
                check_dbi_byte(name, exp_data_q[compared], d);
            end else begin
                protocol_errors++;
                $display("Extra DBI write of %02h with dcx %0b beyond the %0d expected",
                         d, c, exp_data_q.size());
            end
            compared++;
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge sys_clk);
            cycle_cnt++;
        end
        $display("Timeout after %0d cycles with %0d of %0d DBI writes seen",
                 cycle_cnt, compared, exp_data_q.size());
        print_counts();
        $display("Testbench failed");
        $finish;
    end

    initial begin : drive_camera
        int p;
        int k;
        dvp_d     = '0;
        dvp_href  = 1'b0;
        dvp_vsync = 1'b0;
        dvp_pclk  = 1'b0;
        lcg_state = 32'd27;
        build_stimulus();
        build_expected();

        @(posedge sys_clk);
        while (rst) @(posedge sys_clk);

        // Data, href and vsync change while pclk is low
        for (p = 0; p < stim_d_q.size(); p++) begin
            for (k = 0; k < PCLK_CYCLES; k++) begin
                if (k == 0) begin
                    dvp_pclk  <= 1'b0;
                    dvp_d     <= stim_d_q[p];
                    dvp_href  <= stim_href_q[p];
                    dvp_vsync <= stim_vsync_q[p];
                end else if (k == PCLK_CYCLES / 2) begin
                    dvp_pclk <= 1'b1;
                end
                @(posedge sys_clk);
            end
        end
        dvp_pclk <= 1'b0;
        dvp_href <= 1'b0;

        while (compared < exp_data_q.size()) @(posedge sys_clk);
        repeat (DRAIN_CYCLES) @(posedge sys_clk);   // Room for late extra writes

        if (!resx_released) begin
            protocol_errors++;
            $display("Display reset was never released");
        end
        if (dut.u_stream_ctrl.state != cam_pkg::CTRL_STREAM) begin
            protocol_errors++;
            $display("Control FSM is not streaming at the end of the run");
        end

        print_counts();
        if (byte_errors + dcx_errors + cycle_errors + pin_errors + protocol_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
source/cam_pkg.sv
source/dvp_sampler.sv
source/pixel_fifo.sv
source/dbi_writer.sv
source/stream_ctrl.sv
source/image_stream_top.sv
dv/tb_clock_gen.sv
dv/tb_image_stream.sv

/* Makefile */
TOP := tb_image_stream

.PHONY: compile run clean

compile:
	verilator --binary --timing -j 0 --top-module $(TOP) -f sources.f -o V$(TOP)

run: compile
	./obj_dir/V$(TOP) | tee run.log
	grep -q "^Testbench passed$$" run.log

clean:
	rm -rf obj_dir run.log
